// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART command master testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

top=uart_cmd_master_tb
obj_dir=obj_dir

verilator --binary --assert -f sources.f --top-module "$top" -Mdir "$obj_dir" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$("./$obj_dir/$top")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if ! echo "$output" | grep -q "TB PASSED"; then
  exit 1
fi
exit 0

// File: sources.f
verilog/uart_frame_pkg.sv
verilog/uart_cmd_pkg.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_sequencer.sv
verilog/uart_cmd_master.sv
verification/uart_cmd_master_tb.sv

// File: verification/uart_cmd_master_tb.sv
`timescale 1ns/1ps

module uart_cmd_master_tb;

  localparam int num_cmds    = 60;
  localparam int cmd_clks    = 600;  // two frames, the gap and the longest reply fit in this.
  localparam int reset_clks  = 4;
  localparam int timeout_cyc = num_cmds * cmd_clks + reset_clks;
  localparam int drive_dly   = 2;
  localparam int bit_clks    = uart_frame_pkg::clks_per_bit;
  localparam int frame_clks  = uart_frame_pkg::frame_bits * bit_clks;
  localparam int start_lat   = 2;  // accepting sample to the first low sample on tx.

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic [uart_cmd_pkg::cmd_w-1:0]  cmd_in;
  logic                            cmd_vld;
  logic                            rx = 1'b1;
  logic                            tx;
  logic                            cmd_rdy;
  logic [uart_cmd_pkg::data_w-1:0] read_data;
  logic                            read_rdy;
  logic                            read_err;

  integer seed    = 64;
  int     errors  = 0;
  int     checks  = 0;
  int     mon_cyc = 0;

  // remote device table and the queues between driver, line decoder and device.
  logic [7:0] table_mem [0:127];
  logic [6:0] reply_q [$];
  int         delay_q [$];
  logic       flip_q [$];
  logic [7:0] exp_data_q [$];
  logic       exp_err_q [$];

  logic                    reset_seen = 1'b0;
  logic                    in_frame   = 1'b0;
  logic                    cmd_open   = 1'b0;  // accepted command still owes frames.
  logic                    want_data  = 1'b0;
  logic                    width_ok;
  logic                    first_val;
  logic [10:0]             frame_q;
  int                      frame_pos;
  int                      fall_cyc;
  int                      acc_cyc;
  int                      last_stop_cyc;
  uart_cmd_pkg::cmd_word_t cur_cmd;

  uart_cmd_master u_uart_cmd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  always #20 clk = ~clk;

  task automatic check_value(input int got, input int exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command driver.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fill_table();
    logic [31:0] rnd;
    int          i;
    for (i = 0; i < 128; i++)
    begin
      rnd = $random(seed);
      table_mem[i[6:0]] = rnd[7:0];
    end
  endtask

  task automatic issue_commands();
    uart_cmd_pkg::cmd_word_t cmd;
    logic [31:0]             rnd;
    int                      sent;
    sent = 0;
    while (sent < num_cmds)
    begin
      @(posedge clk);
      #drive_dly;
      rnd = $random(seed);
      if (cmd_rdy)
      begin
        cmd.write_view.rw    = rnd[0];
        cmd.write_view.addr  = {3'b000, rnd[4:1]};  // small window so reads hit earlier writes.
        cmd.write_view.wdata = rnd[15:8];  // doubles as the reserved byte of a read.
        if (cmd.read_view.rw != uart_cmd_pkg::cmd_write)
        begin
          delay_q.push_back(int'(rnd[21:16]));
          flip_q.push_back(rnd[25:24] == 2'b00);
        end
        cmd_in  = cmd;
        cmd_vld = 1'b1;
        sent++;
      end
      else
      begin
        cmd_in  = rnd[31:16];
        cmd_vld = (rnd[1:0] == 2'b11);  // garbage while busy, must be dropped.
      end
    end
    @(posedge clk);
    #drive_dly;
    cmd_vld = 1'b0;
  endtask

  task automatic wait_for_idle();
    do
    begin
      @(posedge clk);
      #drive_dly;
    end
    while (!cmd_rdy || cmd_open || in_frame || reply_q.size() != 0 ||
           exp_data_q.size() != 0);
    repeat (bit_clks) @(posedge clk);  // room for a stray frame to show.
    check_value(int'(in_frame), 0, "stray frame on tx after the last command");
  endtask

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    fill_table();
    repeat (reset_clks) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;
    issue_commands();
    wait_for_idle();
    finish_run();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Remote device.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_reply(input logic [6:0] addr);
    logic [10:0] frame;
    logic [7:0]  data;
    logic        flip;
    int          delay;
    int          i;
    delay = delay_q.pop_front();
    flip  = flip_q.pop_front();
    data  = table_mem[addr];
    frame = {1'b1, ^data ^ flip, data, 1'b0};  // even parity unless flipped.
    exp_data_q.push_back(data);
    exp_err_q.push_back(flip);
    repeat (delay + 1) @(posedge clk);
    for (i = 0; i < uart_frame_pkg::frame_bits; i++)
    begin
      #drive_dly;
      rx = frame[i[3:0]];
      repeat (bit_clks) @(posedge clk);
    end
    #drive_dly;
    rx = 1'b1;
  endtask

  always
  begin
    @(posedge clk);
    if (reply_q.size() != 0) send_reply(reply_q.pop_front());
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line decoder and result checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic frame_done();
    logic [7:0] data;
    int         idle;
    data = frame_q[8:1];
    check_value(int'(frame_q[0]), 0, "start bit");
    check_value(int'(frame_q[9]), int'(^data), "parity bit");
    check_value(int'(frame_q[10]), 1, "stop bit");
    check_value(int'(width_ok), 1, "bit period");
    if (!cmd_open)
    begin
      errors++;
      $display("extra frame on tx at %0t ns without an accepted command", $time);
    end
    else if (!want_data)
    begin
      check_value(fall_cyc - acc_cyc, start_lat, "start latency");
      check_value(int'(data), int'({cur_cmd.write_view.rw, cur_cmd.write_view.addr}),
                  "address frame");
      if (cur_cmd.write_view.rw == uart_cmd_pkg::cmd_write)
      begin
        want_data     = 1'b1;
        last_stop_cyc = mon_cyc;
      end
      else
      begin
        reply_q.push_back(cur_cmd.read_view.addr);
        cmd_open = 1'b0;
      end
    end
    else
    begin
      idle = fall_cyc - last_stop_cyc - 1;
      check_value(int'(idle >= uart_cmd_pkg::gap_clks), 1, "gap between write frames");
      check_value(int'(data), int'(cur_cmd.write_view.wdata), "data frame");
      table_mem[cur_cmd.write_view.addr] = data;
      want_data = 1'b0;
      cmd_open  = 1'b0;
    end
  endtask

  task automatic sample_line();
    int bit_idx;
    int offs;
    if (!in_frame && !tx)
    begin
      in_frame  = 1'b1;
      frame_pos = 0;
      width_ok  = 1'b1;
      fall_cyc  = mon_cyc;
    end
    if (in_frame)
    begin
      bit_idx = frame_pos / bit_clks;
      offs    = frame_pos % bit_clks;
      if (offs == 0) first_val = tx;
      else if (tx != first_val) width_ok = 1'b0;  // every sample of a bit must agree.
      if (offs == bit_clks / 2) frame_q[bit_idx[3:0]] = tx;
      frame_pos++;
      if (frame_pos == frame_clks)
      begin
        in_frame = 1'b0;
        frame_done();
      end
    end
  endtask

  task automatic check_read();
    logic [7:0] exp_data;
    logic       exp_err;
    check_value(int'(cmd_rdy), 1, "cmd_rdy with read_rdy");
    if (exp_data_q.size() == 0)
    begin
      errors++;
      $display("read_rdy pulsed at %0t ns with no reply sent", $time);
    end
    else
    begin
      exp_data = exp_data_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      check_value(int'(read_data), int'(exp_data), "read data");
      check_value(int'(read_err), int'(exp_err), "read error flag");
    end
  endtask

  // outputs settle after the rising edge, so everything is sampled on the falling one.
  always @(negedge clk)
  begin
    mon_cyc++;
    if (mon_cyc >= timeout_cyc)
    begin
      errors++;
      $display("timeout: DUT stopped responding after %0d cycles", mon_cyc);
      finish_run();
    end
    else if (rst_n)
    begin
      if (!reset_seen)
      begin
        check_value(int'(tx), 1, "tx after reset");
        check_value(int'(cmd_rdy), 1, "cmd_rdy after reset");
        check_value(int'(read_rdy), 0, "read_rdy after reset");
        check_value(int'(read_err), 0, "read_err after reset");
        reset_seen = 1'b1;
      end
      if (cmd_vld && cmd_rdy)
      begin
        acc_cyc   = mon_cyc;  // the DUT takes it on the next rising edge.
        cur_cmd   = cmd_in;
        cmd_open  = 1'b1;
        want_data = 1'b0;
      end
      if (read_rdy) check_read();
      sample_line();
    end
  end

endmodule

// File: verilog/uart_cmd_master.sv
`timescale 1ns/1ps

module uart_cmd_master (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [uart_cmd_pkg::cmd_w-1:0]   cmd_in,
  input  logic                             cmd_vld,
  input  logic                             rx,
  output logic                             tx,
  output logic                             cmd_rdy,
  output logic [uart_cmd_pkg::data_w-1:0]  read_data,
  output logic                             read_rdy,
  output logic                             read_err
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Links between sequencer and the two frame blocks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                            tx_start;
  logic [uart_cmd_pkg::data_w-1:0] tx_byte;
  logic                            tx_busy;
  logic                            rx_en;
  logic                            rx_done;
  logic [uart_cmd_pkg::data_w-1:0] rx_byte;
  logic                            rx_err;

  uart_cmd_sequencer u_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),  // decoded through the union inside.
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_en     (rx_en),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx_frame u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_en   (rx_en),
    .rx_done (rx_done),
    .rx_byte (rx_byte),
    .rx_err  (rx_err)
  );

endmodule

// File: verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command word.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int cmd_w  = 16;
  localparam int addr_w = 7;
  localparam int data_w = 8;

  localparam logic cmd_write = 1'b1;  // rw value of a write.

  typedef struct packed {
    logic              rw;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } write_view_t;

  typedef struct packed {
    logic              rw;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] rsvd;  // ignored on a read.
  } read_view_t;

  typedef union packed {
    write_view_t write_view;
    read_view_t  read_view;
  } cmd_word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencer timing and states.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int gap_clks  = 16;  // idle clocks between the two write frames.
  localparam int gap_cnt_w = 5;
  localparam logic [gap_cnt_w-1:0] gap_last = gap_cnt_w'(gap_clks - 1);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_send_addr  = 3'd1;
  localparam logic [2:0] st_gap        = 3'd2;
  localparam logic [2:0] st_send_data  = 3'd3;
  localparam logic [2:0] st_wait_reply = 3'd4;

endpackage

// File: verilog/uart_cmd_sequencer.sv
`timescale 1ns/1ps

module uart_cmd_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  uart_cmd_pkg::cmd_word_t           cmd_in,
  input  logic                              cmd_vld,
  input  logic                              tx_busy,
  input  logic                              rx_done,
  input  logic [uart_cmd_pkg::data_w-1:0]   rx_byte,
  input  logic                              rx_err,
  output logic                              cmd_rdy,
  output logic                              tx_start,
  output logic [uart_cmd_pkg::data_w-1:0]   tx_byte,
  output logic                              rx_en,
  output logic                              read_rdy,
  output logic [uart_cmd_pkg::data_w-1:0]   read_data,
  output logic                              read_err
);

  logic [2:0]                           state;
  logic [uart_cmd_pkg::gap_cnt_w-1:0]   gap_cnt;
  uart_cmd_pkg::cmd_word_t              cmd_q;
  logic                                 accept;
  logic                                 frame_end;

  assign accept    = (state == uart_cmd_pkg::st_idle) && cmd_vld;
  // tx_busy only rises a cycle after the pulse, so wait for the pulse to clear first.
  assign frame_end = !tx_start && !tx_busy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transaction FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::st_idle;
      gap_cnt  <= '0;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      rx_en    <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        uart_cmd_pkg::st_idle:
        begin
          if (accept)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= uart_cmd_pkg::st_send_addr;
          end
        end
        uart_cmd_pkg::st_send_addr:
        begin
          if (frame_end)
          begin
            gap_cnt <= '0;
            if (cmd_q.write_view.rw == uart_cmd_pkg::cmd_write)
            begin
              state <= uart_cmd_pkg::st_gap;
            end
            else
            begin
              rx_en <= 1'b1;  // reply can only start after our frame.
              state <= uart_cmd_pkg::st_wait_reply;
            end
          end
        end
        uart_cmd_pkg::st_gap:
        begin
          if (gap_cnt == uart_cmd_pkg::gap_last)
          begin
            tx_start <= 1'b1;
            state    <= uart_cmd_pkg::st_send_data;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_cmd_pkg::st_send_data:
        begin
          if (frame_end)
          begin
            cmd_rdy <= 1'b1;
            state   <= uart_cmd_pkg::st_idle;
          end
        end
        default:
        begin
          if (rx_done)
          begin
            rx_en    <= 1'b0;
            read_rdy <= 1'b1;
            read_err <= rx_err;
            cmd_rdy  <= 1'b1;
            state    <= uart_cmd_pkg::st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in.read_view.rw, cmd_in.read_view.addr};  // rw tells the remote side.
    end
    else if (state == uart_cmd_pkg::st_gap)
    begin
      tx_byte <= cmd_q.write_view.wdata;
    end
    if (state == uart_cmd_pkg::st_wait_reply && rx_done)
    begin
      read_data <= rx_byte;
    end
  end

  a_read_rdy_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> $past(state) == uart_cmd_pkg::st_wait_reply)
    else $error("read_rdy outside a read reply.");

  a_rdy_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> state == uart_cmd_pkg::st_idle)
    else $error("cmd_rdy high during a transaction.");

endmodule

// File: verilog/uart_frame_pkg.sv
package uart_frame_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial line timing and frame layout.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int clks_per_bit = 16;  // kept short so simulation runs fast.
  localparam int frame_bits   = 11;  // start, 8 data, parity, stop.
  localparam int data_bits    = 8;
  localparam int bit_cnt_w    = 4;
  localparam int baud_cnt_w   = 5;

  localparam logic parity_odd = 1'b0;  // zero selects even parity.

  // Counter end values, sized to match the counters.
  localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(clks_per_bit - 1);
  localparam logic [baud_cnt_w-1:0] baud_mid  = baud_cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [bit_cnt_w-1:0]  tx_bit_last = bit_cnt_w'(frame_bits - 1);
  localparam logic [bit_cnt_w-1:0]  rx_bit_last = bit_cnt_w'(frame_bits - 2);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receiver FSM encoding.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [1:0] rx_hunt  = 2'd0;  // waiting for a falling edge.
  localparam logic [1:0] rx_start = 2'd1;  // confirming the start bit.
  localparam logic [1:0] rx_bits  = 2'd2;  // data, parity and stop.
  localparam logic [1:0] rx_check = 2'd3;  // result goes out here.

endpackage

// File: verilog/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rx,
  input  logic                                 rx_en,
  output logic                                 rx_done,
  output logic [uart_frame_pkg::data_bits-1:0] rx_byte,
  output logic                                 rx_err
);

  logic                                    rx_meta;
  logic                                    rx_sync;
  logic                                    rx_prev;
  logic [1:0]                              state;
  logic [uart_frame_pkg::baud_cnt_w-1:0]   baud_cnt;
  logic [uart_frame_pkg::bit_cnt_w-1:0]    bit_cnt;
  logic [uart_frame_pkg::frame_bits-2:0]   shreg;
  logic                                    sample_tick;
  logic                                    parity_bad;
  logic                                    stop_bad;

  assign sample_tick = (state == uart_frame_pkg::rx_bits) &&
                       (baud_cnt == uart_frame_pkg::baud_last);
  assign parity_bad  = ^shreg[uart_frame_pkg::data_bits:0] ^ uart_frame_pkg::parity_odd;
  assign stop_bad    = !shreg[uart_frame_pkg::data_bits+1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Synchronizer and frame FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= uart_frame_pkg::rx_hunt;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_done  <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      rx_done <= 1'b0;
      case (state)
        uart_frame_pkg::rx_hunt:
        begin
          baud_cnt <= '0;
          if (rx_en && rx_prev && !rx_sync)
          begin
            state <= uart_frame_pkg::rx_start;
          end
        end
        uart_frame_pkg::rx_start:
        begin
          if (baud_cnt == uart_frame_pkg::baud_mid)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? uart_frame_pkg::rx_hunt : uart_frame_pkg::rx_bits;  // glitch.
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        uart_frame_pkg::rx_bits:
        begin
          if (sample_tick)
          begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == uart_frame_pkg::rx_bit_last)
            begin
              state <= uart_frame_pkg::rx_check;  // stop bit was just taken.
            end
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default:
        begin
          rx_done <= 1'b1;
          state   <= uart_frame_pkg::rx_hunt;
        end
      endcase
    end
  end

  // Data bits shift in from the top, so the byte ends up LSB first in shreg[7:0].
  always_ff @(posedge clk)
  begin
    if (sample_tick)
    begin
      shreg <= {rx_sync, shreg[uart_frame_pkg::frame_bits-2:1]};
    end
    if (state == uart_frame_pkg::rx_check)
    begin
      rx_byte <= shreg[uart_frame_pkg::data_bits-1:0];
      rx_err  <= parity_bad | stop_bad;
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_done |=> !rx_done)
    else $error("rx_done held for two cycles.");

endmodule

// File: verilog/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 tx_start,
  input  logic [uart_frame_pkg::data_bits-1:0] tx_byte,
  output logic                                 tx,
  output logic                                 tx_busy
);

  logic [uart_frame_pkg::frame_bits-1:0] shreg;
  logic [uart_frame_pkg::baud_cnt_w-1:0] baud_cnt;
  logic [uart_frame_pkg::bit_cnt_w-1:0]  bit_cnt;
  logic                                  parity;
  logic                                  bit_end;

  assign parity  = ^tx_byte ^ uart_frame_pkg::parity_odd;
  assign bit_end = baud_cnt == uart_frame_pkg::baud_last;
  assign tx      = shreg[0];  // line driven straight from the shift register.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shift out start, data, parity and stop.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg    <= '1;  // idle line is high.
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        shreg    <= {1'b1, parity, tx_byte, 1'b0};
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx_busy  <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      shreg    <= {1'b1, shreg[uart_frame_pkg::frame_bits-1:1]};  // ones fill behind the stop bit.
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
      if (bit_cnt == uart_frame_pkg::tx_bit_last)
      begin
        tx_busy <= 1'b0;  // stop bit has had its full period.
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else $error("tx low while the transmitter is idle.");

  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("tx_start arrived during a frame.");

endmodule
